// File: design/outbound_pkg.sv
package outbound_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths with a meaning
  //////////////////////////////////////////////////////////////////////

  typedef logic [63:0] addr_t;        // memory byte address
  typedef logic [63:0] data_t;        // one stream or memory beat
  typedef logic [7:0]  strb_t;
  typedef logic [7:0]  tuser_t;       // engine side-band code
  typedef logic [63:0] byte_count_t;
  typedef logic [9:0]  beat_count_t;  // up to 512 beats in a burst

  // where the write-data beat comes from
  typedef enum logic [2:0] {
    SRC_HOLD,    // no beat, stream stalled
    SRC_NONE,    // no beat, stream drained while hunting the marker
    SRC_STREAM,  // engine beats pass through
    SRC_PAD,     // zero beats fill the burst
    SRC_SIZE     // single size word
  } beat_src_t;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_WAIT_MARKER,
    ST_BURST_CMD,
    ST_BURST_DATA,
    ST_BURST_PAD,
    ST_BURST_WAIT,
    ST_SIZE_CMD,
    ST_SIZE_DATA,
    ST_SIZE_WAIT,
    ST_DONE
  } kernel_state_t;

  //////////////////////////////////////////////////////////////////////
  // constants
  //////////////////////////////////////////////////////////////////////

  localparam byte_count_t BEAT_BYTES   = 64'd8;
  localparam byte_count_t BURST_BYTES  = 64'd4096;
  localparam beat_count_t BURST_BEATS  = 10'd512;
  localparam byte_count_t SIZE_BYTES   = 64'd8;
  localparam data_t       START_MARKER = 64'ha00000000a000005;
  localparam tuser_t      TUSER_START  = 8'd1;   // goes with the marker word
  localparam tuser_t      TUSER_END    = 8'd2;   // last beat of the frame

endpackage

// File: design/job_if.sv
`timescale 1ns/1ps

// job arguments and byte accounting shared by the three blocks
interface job_if;
  import outbound_pkg::*;

  logic        capture;        // latch job arguments
  logic        burst_open;     // a new burst starts
  logic        beat_accepted;  // one stream beat went to memory
  byte_count_t beat_bytes;
  addr_t       burst_addr;
  addr_t       size_addr;
  byte_count_t total_bytes;    // frame body bytes so far

  modport ctrl (output capture, output burst_open, input burst_addr, input size_addr);
  modport data (output beat_accepted, output beat_bytes, input burst_open,
                input total_bytes);
  modport regs (input capture, input burst_open, input beat_accepted, input beat_bytes,
                output burst_addr, output size_addr, output total_bytes);
endinterface

// beat source select and stream events
interface beat_if;
  import outbound_pkg::*;

  beat_src_t src;
  logic      marker_seen;
  logic      end_accepted;   // end beat, or the size word, went out
  logic      burst_full;

  modport ctrl (output src, input marker_seen, input end_accepted, input burst_full);
  modport data (input src, output marker_seen, output end_accepted, output burst_full);
endinterface

// File: design/job_regs.sv
`timescale 1ns/1ps

module job_regs (
  input  logic                ap_clk,
  input  logic                areset,
  input  outbound_pkg::addr_t output_addr,
  input  outbound_pkg::addr_t output_size_addr,
  job_if.regs                 job
);
  import outbound_pkg::*;

  addr_t out_base;  // output address of this job

  //////////////////////////////////////////////////////////////////////
  // job arguments
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ap_clk) begin
    if (job.capture) begin
      out_base      <= output_addr;
      job.size_addr <= output_size_addr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // byte accounting
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      job.total_bytes <= '0;
    end else if (job.capture) begin
      job.total_bytes <= '0;             // fresh frame
    end else if (job.beat_accepted) begin
      job.total_bytes <= job.total_bytes + job.beat_bytes;
    end
  end

  // each burst starts right after the bytes already written
  always_ff @(posedge ap_clk) begin
    if (job.burst_open) begin
      job.burst_addr <= out_base + job.total_bytes;
    end
  end

endmodule

// File: design/frame_control.sv
`timescale 1ns/1ps

module frame_control (
  input  logic                      ap_clk,
  input  logic                      areset,
  input  logic                      ap_start,
  output logic                      ap_done,
  output logic                      ap_idle,
  output logic                      ap_ready,
  output logic                      wr_cmd_valid,
  input  logic                      wr_cmd_ready,
  output outbound_pkg::addr_t       wr_cmd_addr,
  output outbound_pkg::byte_count_t wr_cmd_bytes,
  input  logic                      wr_done,
  job_if.ctrl                       job,
  beat_if.ctrl                      beat
);
  import outbound_pkg::*;

  kernel_state_t state;
  kernel_state_t state_next;
  logic          full_done;  // last burst beat went out and memory already answered

  assign full_done = beat.burst_full && wr_done;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (ap_start) state_next = ST_WAIT_MARKER;
      end
      ST_WAIT_MARKER: begin
        if (beat.marker_seen) state_next = ST_BURST_CMD;
      end
      ST_BURST_CMD: begin
        if (wr_cmd_ready) state_next = ST_BURST_DATA;
      end
      ST_BURST_DATA: begin
        if (beat.end_accepted) begin
          state_next = ST_BURST_PAD;
        end else if (full_done) begin
          state_next = ST_BURST_CMD;    // wr_done came right after the last beat
        end else if (beat.burst_full) begin
          state_next = ST_BURST_WAIT;
        end
      end
      ST_BURST_PAD: begin
        if (full_done) state_next = ST_SIZE_CMD;
      end
      ST_BURST_WAIT: begin
        if (wr_done) state_next = ST_BURST_CMD;
      end
      ST_SIZE_CMD: begin
        if (wr_cmd_ready) state_next = ST_SIZE_DATA;
      end
      ST_SIZE_DATA: begin
        if (beat.end_accepted) state_next = ST_SIZE_WAIT;
      end
      ST_SIZE_WAIT: begin
        if (wr_done) state_next = ST_DONE;
      end
      ST_DONE:  state_next = ST_IDLE;    // one-cycle done
      default:  state_next = ST_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  assign ap_idle  = (state == ST_IDLE);
  assign ap_ready = (state == ST_IDLE);
  assign ap_done  = (state == ST_DONE);

  assign job.capture    = (state == ST_IDLE) && ap_start;
  assign job.burst_open = ((state == ST_WAIT_MARKER) && beat.marker_seen)
                       || ((state == ST_BURST_WAIT) && wr_done)
                       || ((state == ST_BURST_DATA) && !beat.end_accepted && full_done);

  assign wr_cmd_valid = (state == ST_BURST_CMD) || (state == ST_SIZE_CMD);
  assign wr_cmd_addr  = (state == ST_SIZE_CMD) ? job.size_addr : job.burst_addr;
  assign wr_cmd_bytes = (state == ST_SIZE_CMD) ? SIZE_BYTES : BURST_BYTES;

  always_comb begin
    case (state)
      ST_WAIT_MARKER: beat.src = SRC_NONE;
      ST_BURST_DATA:  beat.src = SRC_STREAM;
      ST_BURST_PAD:   beat.src = SRC_PAD;
      ST_SIZE_DATA:   beat.src = SRC_SIZE;
      default:        beat.src = SRC_HOLD;    // stream stalled, no write beat
    endcase
  end

endmodule

// File: design/write_data_path.sv
`timescale 1ns/1ps

module write_data_path (
  input  logic                 ap_clk,
  input  logic                 areset,
  input  logic                 eng_tvalid,
  output logic                 eng_tready,
  input  outbound_pkg::data_t  eng_tdata,
  input  outbound_pkg::strb_t  eng_tstrb,
  input  outbound_pkg::tuser_t eng_tuser,
  output logic                 wr_data_valid,
  input  logic                 wr_data_ready,
  output outbound_pkg::data_t  wr_data,
  job_if.data                  job,
  beat_if.data                 beat
);
  import outbound_pkg::*;

  beat_count_t beat_cnt;   // beats sent in this burst
  logic        is_marker;
  logic        is_end;
  logic        room;       // burst still takes beats
  logic        wr_fire;

  // bytes in the end beat, an empty strobe means a full beat
  function automatic byte_count_t strb_bytes(strb_t strb);
    byte_count_t n;
    n = '0;
    for (int i = 0; i < 8; i++) begin
      n = n + byte_count_t'(strb[i]);
    end
    if (n == '0) n = BEAT_BYTES;
    return n;
  endfunction

  assign is_marker = (eng_tdata == START_MARKER) && (eng_tuser == TUSER_START);
  assign is_end    = (eng_tuser == TUSER_END);
  assign room      = (beat_cnt != BURST_BEATS);

  //////////////////////////////////////////////////////////////////////
  // beat select and stream gating
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    eng_tready    = 1'b0;
    wr_data_valid = 1'b0;
    wr_data       = '0;
    case (beat.src)
      SRC_NONE: eng_tready = 1'b1;       // drop everything up to the marker
      SRC_STREAM: begin
        eng_tready    = wr_data_ready && room;
        wr_data_valid = eng_tvalid && room;
        wr_data       = eng_tdata;
      end
      SRC_PAD:  wr_data_valid = room;    // zero beats
      SRC_SIZE: begin
        wr_data_valid = 1'b1;
        wr_data       = job.total_bytes;
      end
      default: ;
    endcase
  end

  assign wr_fire = wr_data_valid && wr_data_ready;

  assign job.beat_accepted = wr_fire && (beat.src == SRC_STREAM);
  assign job.beat_bytes    = is_end ? strb_bytes(eng_tstrb) : BEAT_BYTES;

  assign beat.marker_seen  = (beat.src == SRC_NONE) && eng_tvalid && is_marker;
  assign beat.end_accepted = (job.beat_accepted && is_end)
                          || (wr_fire && (beat.src == SRC_SIZE));
  assign beat.burst_full   = !room;

  // burst beat counter, stream and pad beats alike
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      beat_cnt <= '0;
    end else if (job.burst_open) begin
      beat_cnt <= '0;
    end else if (wr_fire && (beat.src == SRC_STREAM || beat.src == SRC_PAD)) begin
      beat_cnt <= beat_cnt + 10'd1;
    end
  end

endmodule

// File: design/cceip_outbound_core.sv
`timescale 1ns/1ps

module cceip_outbound_core (
  input  logic                      ap_clk,
  input  logic                      areset,
  input  logic                      ap_start,
  output logic                      ap_done,
  output logic                      ap_idle,
  output logic                      ap_ready,
  // job arguments
  input  outbound_pkg::addr_t       output_addr,
  input  outbound_pkg::addr_t       output_size_addr,
  // engine output stream
  input  logic                      eng_tvalid,
  output logic                      eng_tready,
  input  outbound_pkg::data_t       eng_tdata,
  input  outbound_pkg::strb_t       eng_tstrb,
  input  outbound_pkg::tuser_t      eng_tuser,
  // memory write port
  output logic                      wr_cmd_valid,
  input  logic                      wr_cmd_ready,
  output outbound_pkg::addr_t       wr_cmd_addr,
  output outbound_pkg::byte_count_t wr_cmd_bytes,
  output logic                      wr_data_valid,
  input  logic                      wr_data_ready,
  output outbound_pkg::data_t       wr_data,
  input  logic                      wr_done
);

  job_if  job ();
  beat_if beat ();

  job_regs u_job_regs (
    .ap_clk           (ap_clk),
    .areset           (areset),
    .output_addr      (output_addr),
    .output_size_addr (output_size_addr),
    .job              (job.regs)
  );

  frame_control u_frame_control (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .ap_start     (ap_start),
    .ap_done      (ap_done),
    .ap_idle      (ap_idle),
    .ap_ready     (ap_ready),
    .wr_cmd_valid (wr_cmd_valid),
    .wr_cmd_ready (wr_cmd_ready),
    .wr_cmd_addr  (wr_cmd_addr),
    .wr_cmd_bytes (wr_cmd_bytes),
    .wr_done      (wr_done),
    .job          (job.ctrl),
    .beat         (beat.ctrl)
  );

  write_data_path u_write_data_path (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .eng_tvalid    (eng_tvalid),
    .eng_tready    (eng_tready),
    .eng_tdata     (eng_tdata),
    .eng_tstrb     (eng_tstrb),
    .eng_tuser     (eng_tuser),
    .wr_data_valid (wr_data_valid),
    .wr_data_ready (wr_data_ready),
    .wr_data       (wr_data),
    .job           (job.data),
    .beat          (beat.data)
  );

endmodule

// File: dv/outbound_core_properties.sv
`timescale 1ns/1ps

module outbound_core_properties (
  input logic                ap_clk,
  input logic                areset,
  input logic                ap_idle,
  input logic                ap_done,
  input logic                eng_tready,
  input logic                wr_cmd_valid,
  input logic                wr_cmd_ready,
  input outbound_pkg::addr_t wr_cmd_addr
);

  // no stream beat is taken while the kernel sits idle
  a_idle_no_stream: assert property (@(posedge ap_clk) disable iff (areset)
    ap_idle |-> !eng_tready)
    else $error("eng_tready high while ap_idle is high");

  // command holds with a stable address until memory takes it
  a_cmd_hold: assert property (@(posedge ap_clk) disable iff (areset)
    wr_cmd_valid && !wr_cmd_ready |=> wr_cmd_valid && $stable(wr_cmd_addr))
    else $error("write command dropped or changed before wr_cmd_ready");

  a_done_pulse: assert property (@(posedge ap_clk) disable iff (areset)
    ap_done |=> !ap_done)  // single-cycle done
    else $error("ap_done high for two cycles");

endmodule

// File: dv/tb_cceip_outbound_core.sv
`timescale 1ns/1ps

module tb_cceip_outbound_core;
  import outbound_pkg::*;

  localparam int TIMEOUT_CYCLES = 4 * 1200 * 4;  // frames x beats x cycles per beat

  logic        ap_clk = 1'b0;
  logic        areset;
  logic        ap_start;
  logic        ap_done;
  logic        ap_idle;
  logic        ap_ready;
  addr_t       output_addr;
  addr_t       output_size_addr;
  logic        eng_tvalid = 1'b0;
  logic        eng_tready;
  data_t       eng_tdata = '0;
  strb_t       eng_tstrb = '0;
  tuser_t      eng_tuser = '0;
  logic        wr_cmd_valid;
  logic        wr_cmd_ready = 1'b0;
  addr_t       wr_cmd_addr;
  byte_count_t wr_cmd_bytes;
  logic        wr_data_valid;
  logic        wr_data_ready = 1'b0;
  data_t       wr_data;
  logic        wr_done = 1'b0;

  integer      seed = 22;
  logic [31:0] rnd;                 // one draw per cycle, shared by the models
  bit          stress = 1'b0;       // gaps on the stream, back-pressure on memory
  int          cycle_cnt = 0;
  int          done_pulses = 0;
  event        frame_done;
  event        compare_done;

  data_t       s_data[$];           // engine beats still to send
  strb_t       s_strb[$];
  tuser_t      s_user[$];
  data_t       body[$];             // frame body after the marker
  strb_t       end_strb;
  addr_t       base_addr;
  addr_t       size_at;
  byte_count_t size_expect;

  data_t       mem[addr_t];
  data_t       exp_mem[addr_t];
  addr_t       cmd_addr_q[$];
  addr_t       exp_cmd_addr[$];
  byte_count_t cmd_bytes_q[$];
  byte_count_t exp_cmd_bytes[$];
  logic        cmd_active = 1'b0;
  addr_t       cmd_addr = '0;
  int          beats_left = 0;
  int          beat_idx = 0;
  int          done_wait = 0;

  cceip_outbound_core UUT (.*);

  bind cceip_outbound_core outbound_core_properties u_properties (.ap_clk, .areset,
    .ap_idle, .ap_done, .eng_tready, .wr_cmd_valid, .wr_cmd_ready, .wr_cmd_addr);

  initial begin
    forever #4 ap_clk = ~ap_clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input byte_count_t got,
                             input byte_count_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  always @(posedge ap_clk) begin : cycle_counter
    rnd = $random(seed);
    cycle_cnt = cycle_cnt + 1;
    if (ap_start && ap_idle) done_pulses = 0;
    else if (ap_done) done_pulses = done_pulses + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles waiting for ap_done", cycle_cnt);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // engine and memory models
  ////////////////////////////////////////////////////////////////////////

  always @(posedge ap_clk) begin : engine_model
    logic fire;
    fire = eng_tvalid && eng_tready;
    if (fire) begin
      void'(s_data.pop_front());
      void'(s_strb.pop_front());
      void'(s_user.pop_front());
    end
    #1;
    if (fire || !eng_tvalid) begin  // a raised beat holds until taken
      eng_tvalid = (s_data.size() != 0) && (!stress || rnd[1:0] != 2'd0);
      if (eng_tvalid) begin
        eng_tdata = s_data[0];
        eng_tstrb = s_strb[0];
        eng_tuser = s_user[0];
      end
    end
  end

  always @(posedge ap_clk) begin : memory_model
    logic last_beat;
    last_beat = 1'b0;
    if (ap_start && ap_idle) begin  // fresh image for each job
      mem.delete();
      cmd_addr_q.delete();
      cmd_bytes_q.delete();
    end
    if (wr_data_valid && wr_data_ready) begin
      mem[cmd_addr + addr_t'(8 * beat_idx)] = wr_data;
      beat_idx = beat_idx + 1;
      beats_left = beats_left - 1;
      last_beat = (beats_left == 0);
      if (last_beat) cmd_active = 1'b0;
    end
    if (wr_cmd_valid && wr_cmd_ready) begin
      cmd_active = 1'b1;
      cmd_addr = wr_cmd_addr;
      beats_left = int'(wr_cmd_bytes / BEAT_BYTES);
      beat_idx = 0;
      cmd_addr_q.push_back(wr_cmd_addr);
      cmd_bytes_q.push_back(wr_cmd_bytes);
    end
    #1;
    if (last_beat) done_wait = 1 + int'(rnd[6:5]);  // done 1 to 4 cycles later
    wr_done = (done_wait == 1);
    if (done_wait != 0) done_wait = done_wait - 1;
    wr_cmd_ready = !cmd_active && (!stress || rnd[2]);
    wr_data_ready = cmd_active && (!stress || rnd[4:3] != 2'd0);
  end

  ////////////////////////////////////////////////////////////////////////
  // reference and compare
  ////////////////////////////////////////////////////////////////////////

  // body beats in 512-beat bursts, last burst zero padded, then the size word
  function automatic byte_count_t expected_image();
    int n;
    int beats;
    int ones;
    n = body.size();
    beats = (n + 511) / 512 * 512;
    ones = 0;
    exp_mem.delete();
    exp_cmd_addr.delete();
    exp_cmd_bytes.delete();
    for (int i = 0; i < beats; i++) begin
      exp_mem[base_addr + addr_t'(8 * i)] = (i < n) ? body[i] : '0;
    end
    for (int b = 0; b < beats / 512; b++) begin
      exp_cmd_addr.push_back(base_addr + addr_t'(4096 * b));
      exp_cmd_bytes.push_back(64'd4096);
    end
    exp_cmd_addr.push_back(size_at);
    exp_cmd_bytes.push_back(64'd8);
    for (int k = 0; k < 8; k++) ones += int'(end_strb[k]);
    if (ones == 0) ones = 8;        // empty strobe is a full beat
    exp_mem[size_at] = data_t'(8 * (n - 1) + ones);
    return byte_count_t'(8 * (n - 1) + ones);
  endfunction

  always @(frame_done) begin : compare_process
    byte_count_t exp_size;
    exp_size = expected_image();
    check_count("written beats", byte_count_t'(mem.num()), byte_count_t'(exp_mem.num()));
    foreach (exp_mem[a]) begin
      if (!mem.exists(a)) begin
        $display("nothing was written to address %h", a);
        abort_run();
      end
      check_data($sformatf("mem[%h]", a), mem[a], exp_mem[a]);
    end
    check_count("size word", exp_size, size_expect);
    check_count("commands", byte_count_t'(cmd_addr_q.size()),
                byte_count_t'(exp_cmd_addr.size()));
    foreach (exp_cmd_addr[i]) begin
      check_addr($sformatf("wr_cmd_addr[%0d]", i), cmd_addr_q[i], exp_cmd_addr[i]);
      check_count($sformatf("wr_cmd_bytes[%0d]", i), cmd_bytes_q[i], exp_cmd_bytes[i]);
    end
    check_count("ap_done pulses", byte_count_t'(done_pulses), 64'd1);
    check_count("stream beats left", byte_count_t'(s_data.size()), 64'd0);
    check_flag("ap_idle", ap_idle, 1'b1);
    -> compare_done;
  end

  ////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////

  task automatic queue_beat(input data_t d, input strb_t s, input tuser_t u);
    s_data.push_back(d);
    s_strb.push_back(s);
    s_user.push_back(u);
  endtask

  task automatic run_frame(input int n, input strb_t strb, input int n_junk,
                           input addr_t base, input addr_t size_addr,
                           input byte_count_t size_lit);
    body.delete();
    for (int i = 0; i < n_junk; i++) queue_beat({32'hdead_0000, 32'(i)}, 8'hff, 8'h00);
    if (n_junk > 0) begin
      queue_beat(START_MARKER, 8'hff, 8'h00);  // marker word, wrong code
      queue_beat(64'h0, 8'h0f, TUSER_END);     // stray end code
    end
    queue_beat(START_MARKER, 8'hff, TUSER_START);
    for (int i = 0; i < n; i++) begin
      body.push_back({base[31:0] + 32'(8 * i), ~32'(i)});
      queue_beat(body[i], (i == n - 1) ? strb : 8'hff, (i == n - 1) ? TUSER_END : 8'h00);
    end
    base_addr = base;
    size_at = size_addr;
    end_strb = strb;
    size_expect = size_lit;
    #1;
    output_addr = base;
    output_size_addr = size_addr;
    ap_start = 1'b1;
    @(posedge ap_clk);
    #1 ap_start = 1'b0;
    do @(posedge ap_clk); while (!ap_done);
    repeat (2) @(posedge ap_clk);
    -> frame_done;
    @(compare_done);
  endtask

  initial begin : stimulus
    areset = 1'b1;
    ap_start = 1'b0;
    output_addr = '0;
    output_size_addr = '0;
    repeat (5) @(posedge ap_clk);
    #1 areset = 1'b0;
    @(posedge ap_clk);
    check_flag("ap_idle", ap_idle, 1'b1);
    check_flag("ap_ready", ap_ready, 1'b1);
    check_flag("ap_done", ap_done, 1'b0);
    check_flag("wr_cmd_valid", wr_cmd_valid, 1'b0);
    check_flag("wr_data_valid", wr_data_valid, 1'b0);
    check_flag("eng_tready", eng_tready, 1'b0);
    run_frame(20, 8'hff, 6, 64'h1_0000_0000, 64'h8000_0000, 64'd160);
    run_frame(600, 8'hff, 0, 64'h2000_0000, 64'h8000_0040, 64'd4800);
    run_frame(37, 8'h3f, 2, 64'h3000_1000, 64'h8000_0080, 64'd294);
    stress = 1'b1;
    run_frame(700, 8'h00, 9, 64'h4000_0000, 64'h8000_00c0, 64'd5600);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: vlog.f
design/outbound_pkg.sv
design/job_if.sv
design/job_regs.sv
design/frame_control.sv
design/write_data_path.sv
design/cceip_outbound_core.sv
dv/outbound_core_properties.sv
dv/tb_cceip_outbound_core.sv

// File: run.sh
#!/bin/sh
# build and run the outbound core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_cceip_outbound_core -f vlog.f
out=$(./obj_dir/Vtb_cceip_outbound_core 2>&1) || true
echo "$out"
echo "$out" | grep -qx "=== PASS ==="
